//--- flist.f
+incdir+source
source/cmd_pkg.sv
source/unit_if.sv
source/cmd_parser.sv
source/cmd_dispatch.sv
source/rsp_encoder.sv
source/system_unit.sv
source/gpio_unit.sv
source/command_top.sv
test/command_props.sv
test/command_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module command_tb -o command_sim \
	&& ./obj_dir/command_sim +verilator+error+limit+100 | tee /dev/stderr | grep -q "RESULT: PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- test/command_tb.sv
`timescale 1ns/1ns
`include "cmd_macros.svh"

module command_tb;

	localparam int RESET_CYCLES = 16;
	localparam int NUM_CMDS = 24;
	localparam int CMD_BUDGET = 80;  // generous per-command cycle budget.
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_CMDS * CMD_BUDGET;
	localparam int WAIT_LIMIT = 200;
	localparam logic [`NGPIO-1:0] CH3_MASK = `NGPIO'(1) << 3;

	logic clk;
	logic rst_n;
	logic [7:0] msg_data = 8'h00;
	logic msg_ready = 1'b0;
	logic msg_rd_en;
	logic [63:0] systime;
	logic [7:0] send_ring_data;
	logic send_ring_wr_en;
	logic [7:0] send_fifo_data;
	logic send_fifo_wr_en;
	logic [`NGPIO-1:0] gpio;
	logic shutdown;

	logic [7:0] msg_q[$];   // receive queue model.
	logic [7:0] ring_q[$];  // expected ring bytes.
	logic [7:0] len_q[$];   // expected length words.
	int errors;
	int errors_at_start;
	int tests_run;
	int tests_failed;
	integer seed;
	logic [31:0] rnd_lo;
	logic [31:0] rnd_hi;

	command_top command_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.msg_data(msg_data),
		.msg_ready(msg_ready),
		.msg_rd_en(msg_rd_en),
		.systime(systime),
		.send_ring_data(send_ring_data),
		.send_ring_wr_en(send_ring_wr_en),
		.send_fifo_data(send_fifo_data),
		.send_fifo_wr_en(send_fifo_wr_en),
		.gpio(gpio),
		.shutdown(shutdown)
	);

	bind command_top command_props props_inst (
		.clk(clk),
		.rst_n(rst_n),
		.msg_rd_en(msg_rd_en),
		.send_ring_wr_en(send_ring_wr_en),
		.send_fifo_wr_en(send_fifo_wr_en),
		.gpio(gpio),
		.shutdown(shutdown)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	// one byte leaves per read strobe.
	always @(negedge clk) begin
		if (msg_rd_en && msg_q.size() != 0)
			void'(msg_q.pop_front());
		msg_ready = (msg_q.size() != 0);
		msg_data = msg_ready ? msg_q[0] : 8'h00;
	end

	always @(negedge clk) begin
		if (send_ring_wr_en) begin
			assert (ring_q.size() != 0)
			else begin
				$display("ring byte 0x%02h written while no response was expected", send_ring_data);
				errors++;
			end
			if (ring_q.size() != 0) begin
				assert (send_ring_data == ring_q[0])
				else begin
					$display("Fail at %0t ns: ring byte 0x%02h, expected 0x%02h",
						$time, send_ring_data, ring_q[0]);
					errors++;
				end
				void'(ring_q.pop_front());
			end
		end
		if (send_fifo_wr_en) begin
			assert (len_q.size() != 0)
			else begin
				$display("length word written while no response was expected");
				errors++;
			end
			if (len_q.size() != 0) begin
				assert (send_fifo_data == len_q[0])
				else begin
					$display("Fail at %0t ns: length %0d, expected %0d",
						$time, send_fifo_data, len_q[0]);
					errors++;
				end
				void'(len_q.pop_front());
			end
		end
	end

	// byte count from the value ranges.
	function automatic int vlq_len(input logic [31:0] v);
		if (v < 32'h60 || v >= 32'hffffffe0)
			return 1;
		if (v < 32'h3000 || v >= 32'hfffff000)
			return 2;
		if (v < 32'h180000 || v >= 32'hfff80000)
			return 3;
		if (v < 32'hc000000 || v >= 32'hfc000000)
			return 4;
		return 5;
	endfunction

	task automatic push_vlq(input logic [31:0] v, inout int count);
		logic [34:0] s;
		int n;
		n = vlq_len(v);
		s = {{3{v[31]}}, v};
		for (int i = n - 1; i >= 0; i--)
			ring_q.push_back({i != 0, s[7*i +: 7]});  // high group first.
		count += n;
	endtask

	task automatic expect_rsp(input logic [7:0] id, input int nparams,
			input logic [31:0] p0, input logic [31:0] p1);
		int count;
		count = 1;
		ring_q.push_back(id);
		if (nparams > 0)
			push_vlq(p0, count);
		if (nparams > 1)
			push_vlq(p1, count);
		len_q.push_back(8'(count + 1));
	endtask

	task automatic request_version();
		expect_rsp(`RSP_GET_VERSION, 1, `FW_VERSION, 32'd0);
		msg_q.push_back(8'(`CMD_GET_VERSION));
	endtask

	task automatic request_time(input logic [63:0] t);
		systime = t;
		expect_rsp(`RSP_GET_TIME, 2, t[31:0], t[63:32]);
		msg_q.push_back(8'(`CMD_GET_TIME));
	endtask

	task automatic send_set_output(input logic [7:0] ch0, input logic [7:0] ch1,
			input logic [7:0] value);
		msg_q.push_back(8'(`CMD_SET_DIGITAL_OUT));
		msg_q.push_back(ch0);
		msg_q.push_back(ch1);
		msg_q.push_back(value);
	endtask

	task automatic wait_drained(input string what);
		int n;
		n = 0;
		while ((msg_q.size() != 0 || ring_q.size() != 0 || len_q.size() != 0)
				&& n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (msg_q.size() != 0 || ring_q.size() != 0 || len_q.size() != 0) begin
			$display("%s did not complete within %0d cycles", what, WAIT_LIMIT);
			errors++;
		end
	endtask

	task automatic wait_shutdown();
		int n;
		n = 0;
		while (!shutdown && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!shutdown) begin
			$display("shutdown never went high after the shutdown command");
			errors++;
		end
	endtask

	task automatic check_gpio(input logic [`NGPIO-1:0] expected, input string what);
		assert (gpio == expected)
		else begin
			$display("Fail at %0t ns: gpio 0x%02h after %s, expected 0x%02h",
				$time, gpio, what, expected);
			errors++;
		end
	endtask

	task automatic begin_test();
		errors_at_start = errors;
		tests_run++;
	endtask

	task automatic end_test(input string name);
		if (errors == errors_at_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_at_start);
		end
	endtask

	initial begin
		seed = 44;
		rst_n = 1'b0;
		systime = 64'd0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		begin_test();
		request_version();
		wait_drained("get_version");
		end_test("get_version");

		begin_test();
		request_time(64'h00000060_0000005f);
		wait_drained("get_time 1 and 2 bytes");
		request_time(64'hffffefff_00002fff);
		wait_drained("get_time 2 and 3 bytes");
		request_time(64'hfc000000_0017ffff);
		wait_drained("get_time 3 and 4 bytes");
		request_time(64'h0c000000_ffffffe0);
		wait_drained("get_time 1 and 5 bytes");
		request_time(64'h7fffffff_80000000);
		wait_drained("get_time 5 bytes");
		repeat (3) begin
			rnd_lo = $random(seed);
			rnd_hi = $random(seed);
			request_time({rnd_hi, rnd_lo});
			wait_drained("get_time random");
		end
		// second command queued behind a response in flight.
		request_time(64'h00000001_00001234);
		request_version();
		wait_drained("get_time then get_version");
		end_test("get_time");

		begin_test();
		send_set_output(8'h80, 8'h03, 8'h01);
		request_version();
		wait_drained("set_digital_out value 1");
		check_gpio(CH3_MASK, "value 1");
		send_set_output(8'h80, 8'h03, 8'h00);
		request_version();
		wait_drained("set_digital_out value 0");
		check_gpio('0, "value 0");
		send_set_output(8'h80, 8'h03, 8'h7f);
		request_version();
		wait_drained("set_digital_out value -1");
		check_gpio(CH3_MASK, "value -1");
		send_set_output(8'h80, 8'h03, 8'h00);
		request_version();
		wait_drained("set_digital_out clear");
		check_gpio('0, "clear");
		end_test("set_digital_out");

		begin_test();
		send_set_output(8'h80, 8'h03, 8'h01);
		request_version();
		wait_drained("set_digital_out before shutdown");
		check_gpio(CH3_MASK, "set before shutdown");
		msg_q.push_back(8'(`CMD_SHUTDOWN));
		wait_shutdown();
		check_gpio('0, "shutdown");
		send_set_output(8'h80, 8'h03, 8'h01);
		request_version();
		wait_drained("set_digital_out after shutdown");
		check_gpio('0, "set after shutdown");
		assert (shutdown)
		else begin
			$display("Fail at %0t ns: shutdown dropped after a later command", $time);
			errors++;
		end
		end_test("shutdown");

		errors += command_top_inst.props_inst.fail_count;
		$display("tests run %0d, passed %0d, failed %0d, checks failed %0d",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- test/command_props.sv
`timescale 1ns/1ns
`include "cmd_macros.svh"

module command_props (
	input logic clk,
	input logic rst_n,
	input logic msg_rd_en,
	input logic send_ring_wr_en,
	input logic send_fifo_wr_en,
	input logic [`NGPIO-1:0] gpio,
	input logic shutdown
);

	int fail_count = 0;  // read by the testbench.

	rd_gap: assert property (@(posedge clk) disable iff (!rst_n) msg_rd_en |=> !msg_rd_en)
	else begin
		fail_count++;
		$error("msg_rd_en was high in two consecutive cycles");
	end

	// strobes settle one edge into reset.
	quiet_in_reset: assert property (@(posedge clk)
		!rst_n |=> (!send_ring_wr_en && !send_fifo_wr_en))
	else begin
		fail_count++;
		$error("send strobe active during reset");
	end

	gpio_off: assert property (@(posedge clk) disable iff (!rst_n) shutdown |-> (gpio == '0))
	else begin
		fail_count++;
		$error("gpio driven while shutdown is high");
	end

	shutdown_sticky: assert property (@(posedge clk) disable iff (!rst_n) shutdown |=> shutdown)
	else begin
		fail_count++;
		$error("shutdown dropped without a reset");
	end

endmodule

//--- source/command_top.sv
`timescale 1ns/1ns
`include "cmd_macros.svh"

module command_top (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] msg_data,
	input  logic msg_ready,
	output logic msg_rd_en,
	input  logic [63:0] systime,
	output logic [7:0] send_ring_data,
	output logic send_ring_wr_en,
	output logic [7:0] send_fifo_data,
	output logic send_fifo_wr_en,
	output logic [`NGPIO-1:0] gpio,
	output logic shutdown
);
	import cmd_pkg::*;

	logic cmd_valid;
	cmd_id_t cmd;
	cmd_entry_t entry;
	args_t args;
	logic busy;
	logic rsp_start;
	logic [7:0] rsp_id;
	args_t params;
	logic [`ARGS_BITS:0] nparams;
	logic rsp_busy;

	unit_if sys_if ();
	unit_if gpo_if ();

	cmd_parser parser_inst (
		.clk(clk),
		.rst_n(rst_n),
		.msg_data(msg_data),
		.msg_ready(msg_ready),
		.msg_rd_en(msg_rd_en),
		.busy(busy),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.entry(entry),
		.args(args)
	);

	cmd_dispatch dispatch_inst (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.entry(entry),
		.args(args),
		.busy(busy),
		.sys(sys_if.dispatcher),
		.gpo(gpo_if.dispatcher),
		.rsp_start(rsp_start),
		.rsp_id(rsp_id),
		.params(params),
		.nparams(nparams),
		.rsp_busy(rsp_busy)
	);

	rsp_encoder encoder_inst (
		.clk(clk),
		.rst_n(rst_n),
		.rsp_start(rsp_start),
		.rsp_id(rsp_id),
		.params(params),
		.nparams(nparams),
		.rsp_busy(rsp_busy),
		.send_ring_data(send_ring_data),
		.send_ring_wr_en(send_ring_wr_en),
		.send_fifo_data(send_fifo_data),
		.send_fifo_wr_en(send_fifo_wr_en)
	);

	system_unit system_inst (
		.clk(clk),
		.rst_n(rst_n),
		.u(sys_if.unit),
		.systime(systime),
		.shutdown(shutdown)
	);

	gpio_unit gpio_inst (
		.clk(clk),
		.rst_n(rst_n),
		.u(gpo_if.unit),
		.shutdown(shutdown),
		.gpio(gpio)
	);

endmodule

//--- source/gpio_unit.sv
`timescale 1ns/1ns
`include "cmd_macros.svh"

module gpio_unit (
	input  logic clk,
	input  logic rst_n,
	unit_if.unit u,
	input  logic shutdown,
	output logic [`NGPIO-1:0] gpio
);

	localparam int CH_BITS = $clog2(`NGPIO);

	typedef enum logic [1:0] {
		G_IDLE,
		G_WAIT,
		G_VALUE
	} gstate_t;

	gstate_t state;
	logic [`NGPIO-1:0] out_r;
	logic [CH_BITS-1:0] chan;
	logic chan_ok;

	assign u.param_write = 1'b0;
	assign u.param_data = 32'd0;
	// shutdown forces the pins low at once.
	assign gpio = shutdown ? '0 : out_r;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= G_IDLE;
			out_r <= '0;
			u.arg_advance <= 1'b0;
			u.cmd_done <= 1'b0;
		end else begin
			u.arg_advance <= 1'b0;
			u.cmd_done <= 1'b0;
			case (state)
				G_IDLE: if (u.cmd_ready && u.cmd == `CMD_SET_DIGITAL_OUT) begin
					u.arg_advance <= 1'b1;  // channel taken, ask for value.
					state <= G_WAIT;
				end else if (u.cmd_ready) begin
					u.cmd_done <= 1'b1;
				end
				G_WAIT: state <= G_VALUE;
				G_VALUE: begin
					if (!shutdown && chan_ok)
						out_r[chan] <= (u.arg_data != 32'd0);
					u.cmd_done <= 1'b1;
					state <= G_IDLE;
				end
				default: state <= G_IDLE;
			endcase
			if (shutdown)
				out_r <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (state == G_IDLE && u.cmd_ready) begin
			chan <= u.arg_data[CH_BITS-1:0];
			chan_ok <= (u.arg_data < `NGPIO);
		end
	end

endmodule

//--- source/system_unit.sv
`timescale 1ns/1ns
`include "cmd_macros.svh"

module system_unit (
	input  logic clk,
	input  logic rst_n,
	unit_if.unit u,
	input  logic [63:0] systime,
	output logic shutdown
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_TIME_HI,
		S_DONE
	} sstate_t;

	sstate_t state;
	logic [31:0] time_hi;

	assign u.arg_advance = 1'b0;  // no arguments here.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			u.param_write <= 1'b0;
			u.cmd_done <= 1'b0;
			shutdown <= 1'b0;
		end else begin
			u.param_write <= 1'b0;
			u.cmd_done <= 1'b0;
			case (state)
				S_IDLE: if (u.cmd_ready) begin
					case (u.cmd)
						`CMD_GET_VERSION: begin
							u.param_write <= 1'b1;
							state <= S_DONE;
						end
						`CMD_GET_TIME: begin
							u.param_write <= 1'b1;  // low word first.
							state <= S_TIME_HI;
						end
						`CMD_SHUTDOWN: begin
							shutdown <= 1'b1;  // sticky.
							u.cmd_done <= 1'b1;
						end
						default: u.cmd_done <= 1'b1;
					endcase
				end
				S_TIME_HI: begin
					u.param_write <= 1'b1;
					state <= S_DONE;
				end
				S_DONE: begin
					u.cmd_done <= 1'b1;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && u.cmd_ready) begin
			time_hi <= systime[63:32];
			u.param_data <= (u.cmd == `CMD_GET_TIME) ? systime[31:0] : `FW_VERSION;
		end else if (state == S_TIME_HI) begin
			u.param_data <= time_hi;
		end else if (state == S_DONE) begin
			u.param_data <= {24'd0, (u.cmd == `CMD_GET_TIME) ? `RSP_GET_TIME : `RSP_GET_VERSION};
		end
	end

endmodule

//--- source/rsp_encoder.sv
`timescale 1ns/1ns
`include "cmd_macros.svh"

module rsp_encoder (
	input  logic clk,
	input  logic rst_n,
	input  logic rsp_start,
	input  logic [7:0] rsp_id,
	input  cmd_pkg::args_t params,
	input  logic [`ARGS_BITS:0] nparams,
	output logic rsp_busy,
	output logic [7:0] send_ring_data,
	output logic send_ring_wr_en,
	output logic [7:0] send_fifo_data,
	output logic send_fifo_wr_en
);
	import cmd_pkg::*;

	typedef enum logic [1:0] {
		E_IDLE,
		E_SEND,
		E_LEN
	} estate_t;

	estate_t state;
	args_t params_r;
	logic [`ARGS_BITS:0] nparams_r;
	logic [`ARGS_BITS-1:0] cur;
	logic [34:0] shreg;       // groups left aligned.
	logic [2:0] cnt;          // groups left minus one.
	logic [7:0] len;
	logic [31:0] ld_val;
	logic [2:0] ld_groups;
	logic [34:0] ld_shreg;
	logic last_param;

	// drop leading groups that carry only sign.
	function automatic logic [2:0] vlq_groups(input logic [31:0] v);
		logic [34:0] s;
		logic [2:0] n;
		logic stop;
		s = {{3{v[31]}}, v};
		n = 3'd5;
		stop = 1'b0;
		for (int i = 0; i < 4; i++) begin
			if (!stop && (s[34:26] == 9'h1ff || s[34:26] < 9'd3)) begin
				n = n - 3'd1;
				s = s << 7;
			end else begin
				stop = 1'b1;
			end
		end
		return n;
	endfunction

	assign ld_val = (state == E_IDLE) ? params[0] : params_r[cur + 3'd1];
	assign ld_groups = vlq_groups(ld_val);
	assign ld_shreg = {{3{ld_val[31]}}, ld_val} << (7 * (3'd5 - ld_groups));
	assign last_param = (({1'b0, cur} + 1'b1) == nparams_r);
	assign rsp_busy = (state != E_IDLE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= E_IDLE;
			send_ring_wr_en <= 1'b0;
			send_fifo_wr_en <= 1'b0;
		end else begin
			send_ring_wr_en <= 1'b0;
			send_fifo_wr_en <= 1'b0;
			case (state)
				E_IDLE: if (rsp_start) begin
					send_ring_wr_en <= 1'b1;  // id byte.
					state <= (nparams == '0) ? E_LEN : E_SEND;
				end
				E_SEND: begin
					send_ring_wr_en <= 1'b1;
					if (cnt == 3'd0 && last_param)
						state <= E_LEN;
				end
				E_LEN: begin
					send_fifo_wr_en <= 1'b1;
					state <= E_IDLE;
				end
				default: state <= E_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			E_IDLE: if (rsp_start) begin
				params_r <= params;
				nparams_r <= nparams;
				cur <= '0;
				send_ring_data <= rsp_id;
				len <= 8'd1;
				shreg <= ld_shreg;
				cnt <= ld_groups - 3'd1;
			end
			E_SEND: begin
				send_ring_data <= {cnt != 3'd0, shreg[34:28]};  // continuation bit.
				len <= len + 8'd1;
				if (cnt != 3'd0) begin
					shreg <= shreg << 7;
					cnt <= cnt - 3'd1;
				end else begin
					cur <= cur + 3'd1;
					shreg <= ld_shreg;  // next parameter, no gap.
					cnt <= ld_groups - 3'd1;
				end
			end
			E_LEN: send_fifo_data <= len + 8'd1;
			default: ;
		endcase
	end

endmodule

//--- source/cmd_dispatch.sv
`timescale 1ns/1ns
`include "cmd_macros.svh"

module cmd_dispatch (
	input  logic clk,
	input  logic rst_n,
	input  logic cmd_valid,
	input  cmd_pkg::cmd_id_t cmd,
	input  cmd_pkg::cmd_entry_t entry,
	input  cmd_pkg::args_t args,
	output logic busy,
	unit_if.dispatcher sys,
	unit_if.dispatcher gpo,
	output logic rsp_start,
	output logic [7:0] rsp_id,
	output cmd_pkg::args_t params,
	output logic [`ARGS_BITS:0] nparams,
	input  logic rsp_busy
);
	import cmd_pkg::*;

	typedef enum logic [1:0] {
		D_IDLE,
		D_WAIT,
		D_RESP
	} dstate_t;

	dstate_t state;
	cmd_id_t cur_cmd;
	cmd_entry_t cur_entry;
	logic start;
	logic [31:0] arg_data;
	logic [`ARGS_BITS-1:0] arg_ptr;
	logic sel_gpio;
	logic sel_adv;
	logic sel_write;
	logic sel_done;
	logic [31:0] sel_param;
	logic store;

	assign busy = (state != D_IDLE);
	assign sel_gpio = (cur_entry.unit == unit_gpio);

	assign sys.cmd = cur_cmd;
	assign gpo.cmd = cur_cmd;
	assign sys.arg_data = arg_data;
	assign gpo.arg_data = arg_data;
	assign sys.cmd_ready = start && !sel_gpio;
	assign gpo.cmd_ready = start && sel_gpio;

	// only the started unit is listened to.
	assign sel_adv = sel_gpio ? gpo.arg_advance : sys.arg_advance;
	assign sel_write = sel_gpio ? gpo.param_write : sys.param_write;
	assign sel_done = sel_gpio ? gpo.cmd_done : sys.cmd_done;
	assign sel_param = sel_gpio ? gpo.param_data : sys.param_data;
	assign store = (state == D_WAIT) && sel_write && (nparams < `MAX_PARAMS);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= D_IDLE;
			start <= 1'b0;
			rsp_start <= 1'b0;
			nparams <= '0;
		end else begin
			start <= 1'b0;
			rsp_start <= 1'b0;
			case (state)
				D_IDLE: if (cmd_valid) begin
					start <= 1'b1;
					nparams <= '0;
					state <= D_WAIT;
				end
				D_WAIT: begin
					if (store)
						nparams <= nparams + 1'b1;
					if (sel_done)
						state <= cur_entry.has_response ? D_RESP : D_IDLE;
				end
				D_RESP: if (!rsp_busy) begin
					rsp_start <= 1'b1;  // encoder latches everything.
					state <= D_IDLE;
				end
				default: state <= D_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == D_IDLE && cmd_valid) begin
			cur_cmd <= cmd;
			cur_entry <= entry;
			arg_data <= args[0];
			arg_ptr <= 3'd1;
		end
		if (state == D_WAIT && sel_adv) begin
			arg_data <= args[arg_ptr];
			arg_ptr <= arg_ptr + 3'd1;
		end
		if (store)
			params[nparams[`ARGS_BITS-1:0]] <= sel_param;
		if (state == D_WAIT && sel_done)
			rsp_id <= sel_param[7:0];
	end

endmodule

//--- source/cmd_parser.sv
`timescale 1ns/1ns
`include "cmd_macros.svh"

module cmd_parser (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] msg_data,
	input  logic msg_ready,
	output logic msg_rd_en,
	input  logic busy,
	output logic cmd_valid,
	output cmd_pkg::cmd_id_t cmd,
	output cmd_pkg::cmd_entry_t entry,
	output cmd_pkg::args_t args
);
	import cmd_pkg::*;

	typedef enum logic [1:0] {
		P_IDLE,
		P_ARG_START,
		P_ARG_CONT,
		P_OUTPUT
	} pstate_t;

	pstate_t state;
	logic [`ARGS_BITS-1:0] cur_arg;
	logic take;
	logic last_arg;
	cmd_id_t id_in;
	cmd_entry_t lut;

	// ids above the table range map onto an unused id.
	assign id_in = (msg_data[7:`CMD_BITS] != '0) ? '1 : msg_data[`CMD_BITS-1:0];
	assign lut = cmd_lookup(id_in);
	assign take = msg_ready && !msg_rd_en && !busy && !cmd_valid && (state != P_OUTPUT);
	assign last_arg = (cur_arg == entry.nargs - 3'd1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= P_IDLE;
			msg_rd_en <= 1'b0;
			cmd_valid <= 1'b0;
			cur_arg <= '0;
		end else begin
			msg_rd_en <= take;
			cmd_valid <= 1'b0;
			case (state)
				P_IDLE: if (take) begin
					cur_arg <= '0;
					state <= (lut.nargs == '0) ? P_OUTPUT : P_ARG_START;
				end
				P_ARG_START, P_ARG_CONT: if (take && !msg_data[7]) begin
					cur_arg <= cur_arg + 3'd1;  // argument complete.
					state <= last_arg ? P_OUTPUT : P_ARG_START;
				end else if (take) begin
					state <= P_ARG_CONT;
				end
				P_OUTPUT: begin
					cmd_valid <= 1'b1;
					state <= P_IDLE;
				end
				default: state <= P_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take && state == P_IDLE) begin
			cmd <= id_in;
			entry <= lut;
		end
		if (take && state == P_ARG_START) begin
			args[cur_arg] <= {{25{msg_data[6] & msg_data[5]}}, msg_data[6:0]};  // sign extend.
		end
		if (take && state == P_ARG_CONT) begin
			args[cur_arg] <= {args[cur_arg][24:0], msg_data[6:0]};
		end
	end

endmodule

//--- source/unit_if.sv
`timescale 1ns/1ns

interface unit_if;
	import cmd_pkg::*;

	cmd_id_t cmd;
	logic cmd_ready;        // one-cycle start.
	logic [31:0] arg_data;  // current argument.
	logic arg_advance;
	logic param_write;
	logic [31:0] param_data;
	logic cmd_done;         // param_data holds response id here.

	modport unit (
		input  cmd, cmd_ready, arg_data,
		output arg_advance, param_write, param_data, cmd_done
	);

	modport dispatcher (
		output cmd, cmd_ready, arg_data,
		input  arg_advance, param_write, param_data, cmd_done
	);

endinterface

//--- source/cmd_pkg.sv
`include "cmd_macros.svh"

package cmd_pkg;

	typedef logic [`CMD_BITS-1:0] cmd_id_t;

	typedef enum logic {
		unit_system = 1'b0,
		unit_gpio   = 1'b1
	} unit_t;

	typedef struct packed {
		unit_t unit;
		logic [`ARGS_BITS-1:0] nargs;
		logic has_response;
	} cmd_entry_t;

	typedef logic [`MAX_ARGS-1:0][31:0] args_t;

	// ids without an entry fall back to a silent system command.
	function automatic cmd_entry_t cmd_lookup(input cmd_id_t id);
		cmd_entry_t e;
		e = '{unit: unit_system, nargs: 3'd0, has_response: 1'b0};
		case (id)
			`CMD_GET_VERSION:     e = '{unit: unit_system, nargs: 3'd0, has_response: 1'b1};
			`CMD_GET_TIME:        e = '{unit: unit_system, nargs: 3'd0, has_response: 1'b1};
			`CMD_SET_DIGITAL_OUT: e = '{unit: unit_gpio, nargs: 3'd2, has_response: 1'b0};
			`CMD_SHUTDOWN:        e = '{unit: unit_system, nargs: 3'd0, has_response: 1'b0};
			default:              e = '{unit: unit_system, nargs: 3'd0, has_response: 1'b0};
		endcase
		return e;
	endfunction

endpackage

//--- source/cmd_macros.svh
`ifndef CMD_MACROS_SVH
`define CMD_MACROS_SVH

`define CMD_BITS    5
`define MAX_ARGS    8
`define ARGS_BITS   3
`define MAX_PARAMS  8
`define NGPIO       8
`define FW_VERSION  32'h2a5c1e03

`define CMD_GET_VERSION     5'd0
`define CMD_GET_TIME        5'd2
`define CMD_SET_DIGITAL_OUT 5'd15
`define CMD_SHUTDOWN        5'd19

`define RSP_GET_VERSION 8'd0
`define RSP_GET_TIME    8'd1

`endif
